//--- flist.f
+incdir+design
design/corr_types_pkg.sv
design/vis_types_pkg.sv
design/cos_sin_accum.sv
design/vis_bank_ram.sv
design/correlator_block.sv
design/corr_sequencer.sv
design/corr_regs.sv
design/corr_top.sv
dv/corr_tb.sv

//--- run_sim.sh
#!/bin/sh
# Verilator build and run of the correlator testbench

cd "$(dirname "$0")" || exit 1

LOG=sim.log

# Compile testbench and RTL into one executable
verilator --binary --timing -Wno-fatal -f flist.f --top-module corr_tb -o corr_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

# Run and keep the transcript
./obj_dir/corr_sim > "$LOG" 2>&1
if [ $? -ne 0 ]; then
   cat "$LOG"
   echo "simulation exited with an error"
   exit 1
fi
cat "$LOG"

# Result comes from the log only
if grep -qx "Finished with no errors" "$LOG"; then
   exit 0
fi
exit 1

//--- dv/corr_tb.sv
`include "corr_consts.svh"

module corr_tb;

   logic                      clk_x;
   logic                      arst_n;
   logic                      sample_stb;
   corr_types_pkg::ant_word_t sample_re;
   corr_types_pkg::ant_word_t sample_im;
   vis_types_pkg::reg_addr_t  bus_addr;
   logic                      bus_wr;
   logic                      bus_rd;
   logic [`CORR_BUS_BITS-1:0] bus_wdata;
   logic [`CORR_BUS_BITS-1:0] bus_rdata;
   logic                      bus_ack;

   // Samples of the bank being filled and of the last finished bank
   corr_types_pkg::ant_word_t cur_re [$];
   corr_types_pkg::ant_word_t cur_im [$];
   corr_types_pkg::ant_word_t done_re [$];
   corr_types_pkg::ant_word_t done_im [$];
   int                        m_cnt;
   int                        m_len;
   int                        m_sw;
   logic                      m_bank;
   logic                      m_ovf;

   // Outstanding bus accesses, oldest first
   bit                        chk_q [$];
   logic [`CORR_BUS_BITS-1:0] exp_q [$];
   string                     name_q [$];

   int                        errors;
   int                        checks;
   int                        tests;
   int                        test_err0;
   string                     cur_test;

   corr_top u_dut (
      .clk_x      (clk_x),
      .arst_n     (arst_n),
      .sample_stb (sample_stb),
      .sample_re  (sample_re),
      .sample_im  (sample_im),
      .bus_addr   (bus_addr),
      .bus_wr     (bus_wr),
      .bus_rd     (bus_rd),
      .bus_wdata  (bus_wdata),
      .bus_rdata  (bus_rdata),
      .bus_ack    (bus_ack)
   );

   // 10 unit period
   always #5 clk_x = ~clk_x;

   // ------------------------------
   // Reference model
   // ------------------------------
   // Bank flips once block_len samples are in, zero length acts as one
   function automatic void model_accept(input corr_types_pkg::ant_word_t re,
                                        input corr_types_pkg::ant_word_t im);
      int len_eff;
      len_eff = (m_len == 0) ? 1 : m_len;
      if (m_cnt >= len_eff) begin
         done_re = cur_re;
         done_im = cur_im;
         cur_re.delete();
         cur_im.delete();
         m_bank = ~m_bank;
         m_sw++;
         m_cnt = 0;
      end
      cur_re.push_back(re);
      cur_im.push_back(im);
      m_cnt++;
   endfunction

   // Cosine and sine counts of one pair over the finished bank
   function automatic logic [`CORR_BUS_BITS-1:0] ref_vis(input int blk, input int slot);
      corr_types_pkg::ant_pair_t pair;
      int                        a;
      int                        b;
      int                        n_cos;
      int                        n_sin;
      pair  = corr_types_pkg::pair_tables[blk][slot];
      a     = pair.a_index;
      b     = pair.b_index;
      n_cos = 0;
      n_sin = 0;
      foreach (done_re[i]) begin
         if (done_re[i][a] == done_re[i][b]) n_cos++;
         if (done_re[i][a] == done_im[i][b]) n_sin++;
      end
      return {8'd0, 12'(n_sin), 12'(n_cos)};
   endfunction

   function automatic corr_types_pkg::ant_word_t rand_word();
      return corr_types_pkg::ant_word_t'($urandom());
   endfunction

   // ------------------------------
   // Bus access
   // ------------------------------
   task automatic bus_access(input vis_types_pkg::reg_addr_t addr, input bit wr,
                             input logic [`CORR_BUS_BITS-1:0] wdata, input bit chk,
                             input logic [`CORR_BUS_BITS-1:0] exp_val, input string name);
      int waited;
      chk_q.push_back(chk);
      exp_q.push_back(exp_val);
      name_q.push_back(name);
      @(negedge clk_x);
      bus_addr  = addr;
      bus_wdata = wdata;
      bus_wr    = wr;
      bus_rd    = !wr;
      @(negedge clk_x);
      bus_wr = 1'b0;
      bus_rd = 1'b0;
      waited = 1;
      // Ack expected on the second cycle
      while (!bus_ack && waited < 10) begin
         @(negedge clk_x);
         waited++;
      end
      checks++;
      if (!bus_ack) begin
         $display("ERROR: no bus ack within 10 cycles for address %0d", addr);
         $display("Finished with errors");
         $finish;
      end else if (waited != 2) begin
         $display("ERROR: bus ack came %0d cycles after the strobe, not 2", waited);
         errors++;
      end
   endtask

   task automatic read_reg(input vis_types_pkg::reg_addr_t addr,
                           input logic [`CORR_BUS_BITS-1:0] exp_val, input string name);
      bus_access(addr, 1'b0, '0, 1'b1, exp_val, name);
   endtask

   task automatic write_reg(input vis_types_pkg::reg_addr_t addr,
                            input logic [`CORR_BUS_BITS-1:0] data);
      bus_access(addr, 1'b1, data, 1'b0, '0, "");
   endtask

   task automatic check_status();
      read_reg(vis_types_pkg::REG_STATUS, {16'(m_sw), 14'd0, m_ovf, m_bank},
               "bus_rdata STATUS");
   endtask

   // All 24 entries of the inactive bank
   task automatic check_vis_bank();
      vis_types_pkg::reg_addr_t addr;
      for (int blk = 0; blk < `CORR_BLOCKS; blk++) begin
         for (int slot = 0; slot < `CORR_SLOTS; slot++) begin
            addr = vis_types_pkg::REG_VIS_BASE + 6'(`CORR_SLOTS * blk + slot);
            read_reg(addr, ref_vis(blk, slot), $sformatf("bus_rdata VIS[%0d][%0d]", blk, slot));
         end
      end
   endtask

   // ------------------------------
   // Sample stimulus
   // ------------------------------
   // One strobe every 16 cycles
   task automatic send_sample(input corr_types_pkg::ant_word_t re,
                              input corr_types_pkg::ant_word_t im);
      @(negedge clk_x);
      sample_re  = re;
      sample_im  = im;
      sample_stb = 1'b1;
      @(negedge clk_x);
      sample_stb = 1'b0;
      model_accept(re, im);
      repeat (14) @(negedge clk_x);
   endtask

   task automatic fill_bank(input int n);
      repeat (n) send_sample(rand_word(), rand_word());
   endtask

   // Second strobe lands 5 cycles into the sweep and is lost
   task automatic send_overlap();
      corr_types_pkg::ant_word_t re;
      corr_types_pkg::ant_word_t im;
      re = rand_word();
      im = rand_word();
      @(negedge clk_x);
      sample_re  = re;
      sample_im  = im;
      sample_stb = 1'b1;
      @(negedge clk_x);
      sample_stb = 1'b0;
      model_accept(re, im);
      repeat (4) @(negedge clk_x);
      // Dropped sample, kept out of the model
      sample_re  = rand_word();
      sample_im  = rand_word();
      sample_stb = 1'b1;
      @(negedge clk_x);
      sample_stb = 1'b0;
      repeat (9) @(negedge clk_x);
   endtask

   task automatic start_test(input string name);
      cur_test  = name;
      test_err0 = errors;
   endtask

   task automatic end_test();
      @(negedge clk_x);
      tests++;
      if (errors == test_err0) begin
         $display("test %-14s ok", cur_test);
      end else begin
         $display("test %-14s %0d errors", cur_test, errors - test_err0);
      end
   endtask

   // ------------------------------
   // Readout compare
   // ------------------------------
   // Sampled mid-cycle while ack is high
   always @(negedge clk_x) begin
      bit                        do_chk;
      logic [`CORR_BUS_BITS-1:0] exp_val;
      string                     name;
      if (bus_ack && chk_q.size() > 0) begin
         do_chk  = chk_q.pop_front();
         exp_val = exp_q.pop_front();
         name    = name_q.pop_front();
         if (do_chk) begin
            checks++;
            if (bus_rdata !== exp_val) begin
               $display("FAIL %0t %s got %h expected %h", $time, name, bus_rdata, exp_val);
               errors++;
            end
         end
      end
   end

   initial begin
      clk_x      = 1'b0;
      arst_n     = 1'b0;
      sample_stb = 1'b0;
      sample_re  = '0;
      sample_im  = '0;
      bus_addr   = '0;
      bus_wr     = 1'b0;
      bus_rd     = 1'b0;
      bus_wdata  = '0;
      m_cnt      = 0;
      m_len      = 1;
      m_sw       = 0;
      m_bank     = 1'b0;
      m_ovf      = 1'b0;
      errors     = 0;
      checks     = 0;
      tests      = 0;
      // Fixed seed, repeatable stimulus
      void'($urandom(32'he20a));
      repeat (5) @(posedge clk_x);
      @(negedge clk_x);
      arst_n = 1'b1;

      start_test("reset");
      read_reg(vis_types_pkg::REG_STATUS, '0, "bus_rdata STATUS");
      read_reg(vis_types_pkg::REG_BLOCK_LEN, 32'd1, "bus_rdata BLOCK_LEN");
      end_test();

      // Read-only entries ignore writes
      start_test("registers");
      write_reg(vis_types_pkg::REG_BLOCK_LEN, 32'd7);
      m_len = 7;
      read_reg(vis_types_pkg::REG_BLOCK_LEN, 32'd7, "bus_rdata BLOCK_LEN");
      write_reg(vis_types_pkg::REG_VIS_BASE, 32'h00ff_ffff);
      read_reg(vis_types_pkg::REG_VIS_BASE, ref_vis(0, 0), "bus_rdata VIS[0][0]");
      read_reg(vis_types_pkg::REG_BLOCK_LEN, 32'd7, "bus_rdata BLOCK_LEN");
      write_reg(vis_types_pkg::REG_STATUS, '0);
      check_status();
      end_test();

      // 20 samples, the 21st flips the bank
      start_test("accumulation");
      write_reg(vis_types_pkg::REG_BLOCK_LEN, 32'd20);
      m_len = 20;
      fill_bank(21);
      check_status();
      check_vis_bank();
      end_test();

      // Second round reuses bank 0, which must start from zero
      start_test("clearing");
      for (int round = 0; round < 2; round++) begin
         fill_bank(20);
         check_status();
         check_vis_bank();
      end
      end_test();

      start_test("overflow");
      write_reg(vis_types_pkg::REG_BLOCK_LEN, 32'd3);
      m_len = 3;
      send_overlap();
      m_ovf = 1'b1;
      check_status();
      write_reg(vis_types_pkg::REG_STATUS, '0);
      m_ovf = 1'b0;
      check_status();
      fill_bank(2);
      check_status();
      check_vis_bank();
      end_test();

      // Each sample closes a bank of one
      start_test("block_len_1");
      write_reg(vis_types_pkg::REG_BLOCK_LEN, 32'd1);
      m_len = 1;
      repeat (4) begin
         fill_bank(1);
         check_status();
         check_vis_bank();
      end
      end_test();

      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

//--- design/corr_top.sv
`include "corr_consts.svh"

module corr_top (
   input  logic                      clk_x,
   input  logic                      arst_n,
   input  logic                      sample_stb,
   input  corr_types_pkg::ant_word_t sample_re,
   input  corr_types_pkg::ant_word_t sample_im,
   input  vis_types_pkg::reg_addr_t  bus_addr,
   input  logic                      bus_wr,
   input  logic                      bus_rd,
   input  logic [`CORR_BUS_BITS-1:0] bus_wdata,
   output logic [`CORR_BUS_BITS-1:0] bus_rdata,
   output logic                      bus_ack
);

   logic [`CORR_BUS_BITS-1:0] block_len;
   corr_types_pkg::slot_t     rd_slot;
   logic                      slot_en;
   logic                      clear_lvl;
   logic                      active_bank;
   logic                      bank_sw;
   logic                      overflow_stb;
   corr_types_pkg::ant_word_t lat_re;
   corr_types_pkg::ant_word_t lat_im;
   logic                      rb_bank;
   corr_types_pkg::slot_t     rb_slot;
   vis_types_pkg::vis_word_u  rb_data [`CORR_BLOCKS];

   // Sample capture and slot sweep
   corr_sequencer u_seq (
      .clk_x        (clk_x),
      .arst_n       (arst_n),
      .sample_stb   (sample_stb),
      .sample_re    (sample_re),
      .sample_im    (sample_im),
      .block_len    (block_len),
      .rd_slot      (rd_slot),
      .slot_en      (slot_en),
      .clear_lvl    (clear_lvl),
      .active_bank  (active_bank),
      .bank_sw      (bank_sw),
      .overflow_stb (overflow_stb),
      .lat_re       (lat_re),
      .lat_im       (lat_im)
   );

   // Register bus
   corr_regs u_regs (
      .clk_x        (clk_x),
      .arst_n       (arst_n),
      .bus_addr     (bus_addr),
      .bus_wr       (bus_wr),
      .bus_rd       (bus_rd),
      .bus_wdata    (bus_wdata),
      .bus_rdata    (bus_rdata),
      .bus_ack      (bus_ack),
      .active_bank  (active_bank),
      .bank_sw      (bank_sw),
      .overflow_stb (overflow_stb),
      .rb_data0     (rb_data[0]),
      .rb_data1     (rb_data[1]),
      .block_len    (block_len),
      .rb_bank      (rb_bank),
      .rb_slot      (rb_slot)
   );

   // ------------------------------
   // Correlator blocks
   // ------------------------------
   // Same sweep, different pair table
   for (genvar b = 0; b < `CORR_BLOCKS; b++) begin : g_blk
      correlator_block #(
         .BLOCK_ID (b)
      ) u_blk (
         .clk_x       (clk_x),
         .arst_n      (arst_n),
         .rd_slot     (rd_slot),
         .slot_en     (slot_en),
         .clear_lvl   (clear_lvl),
         .active_bank (active_bank),
         .sample_re   (lat_re),
         .sample_im   (lat_im),
         .rb_bank     (rb_bank),
         .rb_slot     (rb_slot),
         .rb_data     (rb_data[b])
      );
   end

endmodule

//--- design/corr_regs.sv
`include "corr_consts.svh"

module corr_regs (
   input  logic                      clk_x,
   input  logic                      arst_n,
   input  vis_types_pkg::reg_addr_t  bus_addr,
   input  logic                      bus_wr,
   input  logic                      bus_rd,
   input  logic [`CORR_BUS_BITS-1:0] bus_wdata,
   output logic [`CORR_BUS_BITS-1:0] bus_rdata,
   output logic                      bus_ack,
   input  logic                      active_bank,
   input  logic                      bank_sw,
   input  logic                      overflow_stb,
   input  vis_types_pkg::vis_word_u  rb_data0,
   input  vis_types_pkg::vis_word_u  rb_data1,
   output logic [`CORR_BUS_BITS-1:0] block_len,
   output logic                      rb_bank,
   output corr_types_pkg::slot_t     rb_slot
);

   logic                      req_q;
   logic                      overflow;
   logic [15:0]               sw_count;
   logic [`CORR_BUS_BITS-1:0] status_word;
   logic [`CORR_BUS_BITS-1:0] reg_val;
   vis_types_pkg::reg_addr_t  addr_q;
   vis_types_pkg::reg_addr_t  vis_off;
   vis_types_pkg::reg_addr_t  vis_slot;
   logic                      is_vis;
   logic                      is_blk1;
   logic                      vis_hit_q;
   logic                      vis_blk_q;
   logic                      vis_hit_d;
   logic                      vis_blk_d;
   vis_types_pkg::vis_word_u  rb_sel;

   // ------------------------------
   // Address decode
   // ------------------------------
   assign is_vis  = (bus_addr >= vis_types_pkg::REG_VIS_BASE) &&
                    (bus_addr <= vis_types_pkg::REG_VIS_LAST);
   assign vis_off = bus_addr - vis_types_pkg::REG_VIS_BASE;
   // Upper twelve entries belong to block 1
   assign is_blk1  = (vis_off >= 6'(`CORR_SLOTS));
   assign vis_slot = is_blk1 ? vis_off - 6'(`CORR_SLOTS) : vis_off;

   // Bank bit, sticky overflow, switch count on top
   assign status_word = {sw_count, 14'd0, overflow, active_bank};

   // Writable state and ack
   always_ff @(posedge clk_x or negedge arst_n) begin
      if (!arst_n) begin
         req_q     <= 1'b0;
         bus_ack   <= 1'b0;
         overflow  <= 1'b0;
         sw_count  <= '0;
         block_len <= {{(`CORR_BUS_BITS-1){1'b0}}, 1'b1};
      end else begin
         req_q   <= bus_rd | bus_wr;
         bus_ack <= req_q;
         if (bus_wr && bus_addr == vis_types_pkg::REG_BLOCK_LEN) begin
            block_len <= bus_wdata;
         end
         // New overflow beats a clear in the same cycle
         if (overflow_stb) begin
            overflow <= 1'b1;
         end else if (bus_wr && bus_addr == vis_types_pkg::REG_STATUS) begin
            overflow <= 1'b0;
         end
         if (bank_sw) begin
            sw_count <= sw_count + 16'd1;
         end
      end
   end

   // ------------------------------
   // Read path
   // ------------------------------
   // Stage 1 drives the RAM readout address, stage 2 holds the select
   always_ff @(posedge clk_x) begin
      addr_q    <= bus_addr;
      vis_hit_q <= is_vis;
      vis_blk_q <= is_blk1;
      rb_slot   <= vis_slot[`CORR_SLOT_BITS-1:0];
      rb_bank   <= ~active_bank;
      vis_hit_d <= vis_hit_q;
      vis_blk_d <= vis_blk_q;
      if (addr_q == vis_types_pkg::REG_BLOCK_LEN) begin
         reg_val <= block_len;
      end else if (addr_q == vis_types_pkg::REG_STATUS) begin
         reg_val <= status_word;
      end else begin
         reg_val <= '0;
      end
   end

   // RAM data arrives together with ack
   assign rb_sel    = vis_blk_d ? rb_data1 : rb_data0;
   assign bus_rdata = vis_hit_d ?
                      {{(`CORR_BUS_BITS - 2*`CORR_ACCUM_BITS){1'b0}}, rb_sel.raw} : reg_val;

endmodule

//--- design/corr_sequencer.sv
`include "corr_consts.svh"

module corr_sequencer (
   input  logic                       clk_x,
   input  logic                       arst_n,
   input  logic                       sample_stb,
   input  corr_types_pkg::ant_word_t  sample_re,
   input  corr_types_pkg::ant_word_t  sample_im,
   input  logic [`CORR_BUS_BITS-1:0]  block_len,
   output corr_types_pkg::slot_t      rd_slot,
   output logic                       slot_en,
   output logic                       clear_lvl,
   output logic                       active_bank,
   output logic                       bank_sw,
   output logic                       overflow_stb,
   output corr_types_pkg::ant_word_t  lat_re,
   output corr_types_pkg::ant_word_t  lat_im
);

   logic                      accept;
   logic                      switch_now;
   logic [`CORR_BUS_BITS-1:0] len_eff;
   logic [`CORR_BUS_BITS-1:0] samp_cnt;

   // Only taken between sweeps
   assign accept = sample_stb & ~slot_en;

   // Zero length behaves as one
   assign len_eff = (block_len == '0) ? {{(`CORR_BUS_BITS-1){1'b0}}, 1'b1} : block_len;

   // Bank is full once len_eff samples are in
   assign switch_now = (samp_cnt >= len_eff);

   // ------------------------------
   // Sweep and bank control
   // ------------------------------
   always_ff @(posedge clk_x or negedge arst_n) begin
      if (!arst_n) begin
         rd_slot      <= '0;
         slot_en      <= 1'b0;
         clear_lvl    <= 1'b0;
         active_bank  <= 1'b0;
         bank_sw      <= 1'b0;
         overflow_stb <= 1'b0;
         samp_cnt     <= '0;
      end else begin
         bank_sw      <= accept & switch_now;
         // Strobe during a sweep is lost
         overflow_stb <= sample_stb & slot_en;
         if (accept) begin
            slot_en   <= 1'b1;
            rd_slot   <= '0;
            clear_lvl <= switch_now;
            if (switch_now) begin
               active_bank <= ~active_bank;
               // This sample is the first of the new bank
               samp_cnt    <= {{(`CORR_BUS_BITS-1){1'b0}}, 1'b1};
            end else begin
               samp_cnt <= samp_cnt + 1'b1;
            end
         end else if (slot_en) begin
            if (rd_slot == corr_types_pkg::slot_t'(`CORR_SLOTS - 1)) begin
               slot_en <= 1'b0;
            end else begin
               rd_slot <= rd_slot + 1'b1;
            end
         end
      end
   end

   // Sample held for the whole sweep
   always_ff @(posedge clk_x) begin
      if (accept) begin
         lat_re <= sample_re;
         lat_im <= sample_im;
      end
   end

endmodule

//--- design/correlator_block.sv
module correlator_block #(
   parameter int BLOCK_ID = 0
) (
   input  logic                      clk_x,
   input  logic                      arst_n,
   input  corr_types_pkg::slot_t     rd_slot,
   input  logic                      slot_en,
   input  logic                      clear_lvl,
   input  logic                      active_bank,
   input  corr_types_pkg::ant_word_t sample_re,
   input  corr_types_pkg::ant_word_t sample_im,
   input  logic                      rb_bank,
   input  corr_types_pkg::slot_t     rb_slot,
   output vis_types_pkg::vis_word_u  rb_data
);

   corr_types_pkg::ant_pair_t pair;
   logic                      ar;
   logic                      br;
   logic                      bi;
   vis_types_pkg::vis_word_u  acc_data;
   vis_types_pkg::vis_word_u  acc_out;
   logic                      en_d1;
   logic                      en_d2;
   corr_types_pkg::slot_t     slot_d1;
   corr_types_pkg::slot_t     slot_d2;
   logic                      bank_d1;
   logic                      bank_d2;

   // ------------------------------
   // Pair select
   // ------------------------------
   // Fixed table per block
   assign pair = corr_types_pkg::pair_tables[BLOCK_ID][rd_slot];

   // Real of a against real and imaginary of b
   assign ar = sample_re[pair.a_index];
   assign br = sample_re[pair.b_index];
   assign bi = sample_im[pair.b_index];

   // ------------------------------
   // Write-back delay line
   // ------------------------------
   // Read at t, add at t+1, write at t+2
   always_ff @(posedge clk_x or negedge arst_n) begin
      if (!arst_n) begin
         en_d1 <= 1'b0;
         en_d2 <= 1'b0;
      end else begin
         en_d1 <= slot_en;
         en_d2 <= en_d1;
      end
   end

   // Write address follows the enable
   // Bank is carried along so a switch mid-pipe lands in the old bank
   always_ff @(posedge clk_x) begin
      slot_d1 <= rd_slot;
      slot_d2 <= slot_d1;
      bank_d1 <= active_bank;
      bank_d2 <= bank_d1;
   end

   // Products and adders
   cos_sin_accum u_accum (
      .clk_x   (clk_x),
      .arst_n  (arst_n),
      .go      (slot_en),
      .clear   (clear_lvl),
      .ar      (ar),
      .br      (br),
      .bi      (bi),
      .acc_in  (acc_data),
      .acc_out (acc_out)
   );

   // Visibility store
   // Accumulate side on the active bank, readout on the other
   vis_bank_ram u_ram (
      .clk_x    (clk_x),
      .we       (en_d2),
      .wr_bank  (bank_d2),
      .wr_slot  (slot_d2),
      .wr_data  (acc_out),
      .acc_bank (active_bank),
      .acc_slot (rd_slot),
      .acc_data (acc_data),
      .rb_bank  (rb_bank),
      .rb_slot  (rb_slot),
      .rb_data  (rb_data)
   );

endmodule

//--- design/vis_bank_ram.sv
`include "corr_consts.svh"

module vis_bank_ram (
   input  logic                     clk_x,
   input  logic                     we,
   input  logic                     wr_bank,
   input  corr_types_pkg::slot_t    wr_slot,
   input  vis_types_pkg::vis_word_u wr_data,
   input  logic                     acc_bank,
   input  corr_types_pkg::slot_t    acc_slot,
   output vis_types_pkg::vis_word_u acc_data,
   input  logic                     rb_bank,
   input  corr_types_pkg::slot_t    rb_slot,
   output vis_types_pkg::vis_word_u rb_data
);

   // Two banks of 16 rows, bank is the address MSB
   localparam int DEPTH = 2 << `CORR_SLOT_BITS;

   logic [$bits(vis_types_pkg::vis_word_u)-1:0] mem [0:DEPTH-1];

   // Counts start at zero
   initial begin
      for (int i = 0; i < DEPTH; i++) begin
         mem[i] = '0;
      end
   end

   // Write port plus two registered read ports
   always_ff @(posedge clk_x) begin
      if (we) begin
         mem[{wr_bank, wr_slot}] <= wr_data.raw;
      end
      acc_data.raw <= mem[{acc_bank, acc_slot}];
      rb_data.raw  <= mem[{rb_bank, rb_slot}];
   end

endmodule

//--- design/cos_sin_accum.sv
module cos_sin_accum (
   input  logic                     clk_x,
   input  logic                     arst_n,
   input  logic                     go,
   input  logic                     clear,
   input  logic                     ar,
   input  logic                     br,
   input  logic                     bi,
   input  vis_types_pkg::vis_word_u acc_in,
   output vis_types_pkg::vis_word_u acc_out
);

   logic                     prod_cos;
   logic                     prod_sin;
   logic                     clear_q;
   vis_types_pkg::vis_word_u base;
   vis_types_pkg::vis_word_u sum;

   // ------------------------------
   // Stage 1 products
   // ------------------------------
   // One-bit multiply is XNOR
   // Captured with go so they line up with the RAM read
   always_ff @(posedge clk_x or negedge arst_n) begin
      if (!arst_n) begin
         prod_cos <= 1'b0;
         prod_sin <= 1'b0;
         clear_q  <= 1'b0;
      end else if (go) begin
         prod_cos <= ar ~^ br;
         prod_sin <= ar ~^ bi;
         clear_q  <= clear;
      end
   end

   // ------------------------------
   // Stage 2 accumulate
   // ------------------------------
   // First sweep after a switch starts from zero
   assign base = clear_q ? '0 : acc_in;

   always_comb begin
      sum.f.cos_count = base.f.cos_count + vis_types_pkg::accum_t'(prod_cos);
      sum.f.sin_count = base.f.sin_count + vis_types_pkg::accum_t'(prod_sin);
   end

   // Sum register feeds the RAM write port
   always_ff @(posedge clk_x) begin
      acc_out <= sum;
   end

endmodule

//--- design/vis_types_pkg.sv
`include "corr_consts.svh"

package vis_types_pkg;

   // One count
   typedef logic [`CORR_ACCUM_BITS-1:0] accum_t;

   // Sine count in the upper half
   typedef struct packed {
      accum_t sin_count;
      accum_t cos_count;
   } vis_fields_t;

   // RAM and bus use raw, the adders use f
   typedef union packed {
      logic [2*`CORR_ACCUM_BITS-1:0] raw;
      vis_fields_t                   f;
   } vis_word_u;

   // ------------------------------
   // Register map
   // ------------------------------
   typedef logic [5:0] reg_addr_t;

   localparam reg_addr_t REG_BLOCK_LEN = 6'd0;
   localparam reg_addr_t REG_STATUS    = 6'd1;
   // VIS at base + 12*block + slot
   localparam reg_addr_t REG_VIS_BASE  = 6'd16;
   localparam reg_addr_t REG_VIS_LAST  = 6'd39;

endpackage

//--- design/corr_types_pkg.sv
`include "corr_consts.svh"

package corr_types_pkg;

   // One sample bit per antenna
   typedef logic [`CORR_ANTENNAS-1:0] ant_word_t;

   // Time-multiplex slot, also the RAM row
   typedef logic [`CORR_SLOT_BITS-1:0] slot_t;

   typedef logic [$clog2(`CORR_ANTENNAS)-1:0] ant_index_t;

   // Second antenna in the upper bits
   typedef struct packed {
      ant_index_t b_index;
      ant_index_t a_index;
   } ant_pair_t;

   typedef ant_pair_t pair_table_t [0:`CORR_SLOTS-1];

   // Block 0 is antenna 0 against 1..12, block 1 is antenna 13 against the rest
   localparam pair_table_t pair_tables [0:`CORR_BLOCKS-1] = '{
      '{'{5'd1, 5'd0}, '{5'd2, 5'd0}, '{5'd3, 5'd0}, '{5'd4, 5'd0},
        '{5'd5, 5'd0}, '{5'd6, 5'd0}, '{5'd7, 5'd0}, '{5'd8, 5'd0},
        '{5'd9, 5'd0}, '{5'd10, 5'd0}, '{5'd11, 5'd0}, '{5'd12, 5'd0}},
      '{'{5'd14, 5'd13}, '{5'd15, 5'd13}, '{5'd16, 5'd13}, '{5'd17, 5'd13},
        '{5'd18, 5'd13}, '{5'd19, 5'd13}, '{5'd20, 5'd13}, '{5'd21, 5'd13},
        '{5'd22, 5'd13}, '{5'd23, 5'd13}, '{5'd0, 5'd13}, '{5'd1, 5'd13}}
   };

endpackage

//--- design/corr_consts.svh
`ifndef CORR_CONSTS_SVH
`define CORR_CONSTS_SVH

// ------------------------------
// Correlator sizing
// ------------------------------

// Width of one cosine or sine count
`define CORR_ACCUM_BITS 12

// Antenna pairs handled by one block
`define CORR_SLOTS 12
`define CORR_SLOT_BITS 4

// Array size and block count
`define CORR_ANTENNAS 24
`define CORR_BLOCKS 2

// Register bus data width
`define CORR_BUS_BITS 32

`endif
